/* periph_settings.svh */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// --------------------
//  bus
// --------------------

`define PERIPH_ADDR_BITS    4
`define PERIPH_DATA_BITS    32

// word addresses
`define ADDR_UART_DATA      4'h0
`define ADDR_UART_STATUS    4'h1
`define ADDR_GPIO_WRITE     4'h4
`define ADDR_GPIO_SET       4'h5
`define ADDR_GPIO_CLEAR     4'h6
`define ADDR_GPIO_TOGGLE    4'h7

// --------------------
//  peripherals
// --------------------

`define GPIO_BITS           4
`define UART_DIVIDER        8

`endif

/* periph_pkg.sv */
package periph_pkg;

    // --------------------
    //  decoder
    // --------------------

    // block targeted by an access
    typedef enum logic [1:0] {
        sel_none,
        sel_uart_data,
        sel_uart_status,
        sel_gpio
    } reg_sel_t;

    // one gpio write variant per address
    typedef enum logic [1:0] {
        op_write,
        op_set,
        op_clear,
        op_toggle
    } gpio_op_t;

    // uart tx frame phases
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_t;

endpackage

/* periph_bus_decode.sv */
`include "periph_settings.svh"

module periph_bus_decode
    import periph_pkg::*;
    (
        input   var logic                               clk         ,
        input   var logic                               rst         ,

        input   var logic                               wr          ,
        input   var logic                               rd          ,
        input   var logic   [`PERIPH_ADDR_BITS-1:0]     addr        ,
        input   var logic   [`PERIPH_DATA_BITS-1:0]     wdata       ,

        output  var logic                               uart_wr     ,
        output  var logic   [7:0]                       uart_data   ,
        output  var logic                               gpio_wr     ,
        output  var gpio_op_t                           gpio_op     ,
        output  var logic   [`GPIO_BITS-1:0]            gpio_data   ,

        input   var logic                               uart_busy   ,
        input   var logic   [`GPIO_BITS-1:0]            gpio_value  ,

        output  var logic   [`PERIPH_DATA_BITS-1:0]     rdata       ,
        output  var logic                               rvalid      ,
        output  var logic                               err
    );

    reg_sel_t                           sel;
    logic   [`PERIPH_DATA_BITS-1:0]     rd_value;
    logic                               bad_access;

    // --------------------
    //  address decode
    // --------------------

    always_comb begin
        sel     = sel_none;
        gpio_op = op_write;
        case (addr)
            `ADDR_UART_DATA:    sel = sel_uart_data;
            `ADDR_UART_STATUS:  sel = sel_uart_status;
            `ADDR_GPIO_WRITE:   sel = sel_gpio;
            `ADDR_GPIO_SET: begin
                sel     = sel_gpio;
                gpio_op = op_set;
            end
            `ADDR_GPIO_CLEAR: begin
                sel     = sel_gpio;
                gpio_op = op_clear;
            end
            `ADDR_GPIO_TOGGLE: begin
                sel     = sel_gpio;
                gpio_op = op_toggle;
            end
            default:            sel = sel_none;
        endcase
    end

    // write strobes go straight through in the strobe cycle
    assign uart_wr   = wr && (sel == sel_uart_data);
    assign uart_data = wdata[7:0];
    assign gpio_wr   = wr && (sel == sel_gpio);
    assign gpio_data = wdata[`GPIO_BITS-1:0];

    // --------------------
    //  read response
    // --------------------

    always_comb begin
        case (sel)
            sel_uart_status:    rd_value = `PERIPH_DATA_BITS'(uart_busy);
            sel_gpio:           rd_value = `PERIPH_DATA_BITS'(gpio_value);
            default:            rd_value = '0;
        endcase
    end

    // status is read only and tx data is write only
    assign bad_access = (rd && (sel == sel_none || sel == sel_uart_data))
                     || (wr && (sel == sel_none || sel == sel_uart_status));

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            err    <= 1'b0;
        end else begin
            rvalid <= rd;
            err    <= bad_access;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= rd_value;
        end
    end

    // master never issues both strobes at once
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(wr && rd));

endmodule

/* periph_uart_tx.sv */
`include "periph_settings.svh"

module periph_uart_tx
    import periph_pkg::*;
    (
        input   var logic           clk         ,
        input   var logic           rst         ,

        input   var logic           uart_wr     ,
        input   var logic   [7:0]   uart_data   ,
        output  var logic           uart_busy   ,
        output  var logic           uart_tx
    );

    localparam int CNT_BITS = $clog2(`UART_DIVIDER + 1);

    uart_state_t            state;
    logic   [CNT_BITS-1:0]  bit_cnt;
    logic   [2:0]           bit_idx;
    logic   [7:0]           shift;
    logic                   bit_end;
    logic                   accept;

    assign accept    = uart_wr && (state == st_idle);
    assign bit_end   = (bit_cnt == CNT_BITS'(`UART_DIVIDER - 1));
    assign uart_busy = (state != st_idle);

    // --------------------
    //  frame FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state   <= st_start;
                        bit_cnt <= '0;
                        uart_tx <= 1'b0;
                    end
                end
                st_start: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        state   <= st_data;
                        bit_idx <= '0;
                        uart_tx <= shift[0];
                    end
                end
                st_data: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state   <= st_stop;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            // next bit ahead of the shift
                            uart_tx <= shift[1];
                        end
                    end
                end
                st_stop: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data shifter sends lsb first
    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= uart_data;
        end else if (state == st_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle) |-> uart_tx);

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (rst)
        bit_cnt < CNT_BITS'(`UART_DIVIDER));

endmodule

/* periph_gpio_reg.sv */
`include "periph_settings.svh"

module periph_gpio_reg
    import periph_pkg::*;
    (
        input   var logic                       clk         ,
        input   var logic                       rst         ,

        input   var logic                       gpio_wr     ,
        input   var gpio_op_t                   gpio_op     ,
        input   var logic   [`GPIO_BITS-1:0]    gpio_data   ,

        output  var logic   [`GPIO_BITS-1:0]    gpio_value
    );

    logic   [`GPIO_BITS-1:0]    next_value;

    // --------------------
    //  update
    // --------------------

    // data acts as a mask except for plain write
    always_comb begin
        case (gpio_op)
            op_write:   next_value = gpio_data;
            op_set:     next_value = gpio_value | gpio_data;
            op_clear:   next_value = gpio_value & ~gpio_data;
            op_toggle:  next_value = gpio_value ^ gpio_data;
            default:    next_value = gpio_value;
        endcase
    end

    // --------------------
    //  pins
    // --------------------

    // same register feeds the pmod pins and readback
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_value <= '0;
        end else if (gpio_wr) begin
            gpio_value <= next_value;
        end
    end

endmodule

/* pmod_periph_top.sv */
`include "periph_settings.svh"

module pmod_periph_top
    import periph_pkg::*;
    (
        input   var logic                               clk     ,
        input   var logic                               rst     ,

        input   var logic                               wr      ,
        input   var logic                               rd      ,
        input   var logic   [`PERIPH_ADDR_BITS-1:0]     addr    ,
        input   var logic   [`PERIPH_DATA_BITS-1:0]     wdata   ,
        output  var logic   [`PERIPH_DATA_BITS-1:0]     rdata   ,
        output  var logic                               rvalid  ,
        output  var logic                               err     ,

        output  var logic   [`GPIO_BITS-1:0]            gpio    ,
        output  var logic                               uart_tx
    );

    logic                       uart_wr;
    logic   [7:0]               uart_data;
    logic                       uart_busy;
    logic                       gpio_wr;
    gpio_op_t                   gpio_op;
    logic   [`GPIO_BITS-1:0]    gpio_data;

    // --------------------
    //  bus
    // --------------------

    periph_bus_decode
        u_bus_decode
            (
                .clk        (clk        ),
                .rst        (rst        ),
                .wr         (wr         ),
                .rd         (rd         ),
                .addr       (addr       ),
                .wdata      (wdata      ),
                .uart_wr    (uart_wr    ),
                .uart_data  (uart_data  ),
                .gpio_wr    (gpio_wr    ),
                .gpio_op    (gpio_op    ),
                .gpio_data  (gpio_data  ),
                .uart_busy  (uart_busy  ),
                .gpio_value (gpio       ),
                .rdata      (rdata      ),
                .rvalid     (rvalid     ),
                .err        (err        )
            );

    // --------------------
    //  peripherals
    // --------------------

    periph_uart_tx
        u_uart_tx
            (
                .clk        (clk        ),
                .rst        (rst        ),
                .uart_wr    (uart_wr    ),
                .uart_data  (uart_data  ),
                .uart_busy  (uart_busy  ),
                .uart_tx    (uart_tx    )
            );

    periph_gpio_reg
        u_gpio_reg
            (
                .clk        (clk        ),
                .rst        (rst        ),
                .gpio_wr    (gpio_wr    ),
                .gpio_op    (gpio_op    ),
                .gpio_data  (gpio_data  ),
                .gpio_value (gpio       )
            );

endmodule

/* tb_pmod_periph_top.sv */
`include "periph_settings.svh"

module tb_pmod_periph_top
    import periph_pkg::*;
    ();

    localparam int FRAME_CYCLES  = 10 * `UART_DIVIDER;
    localparam int READ_TIMEOUT  = 8;
    localparam int START_TIMEOUT = 4 * `UART_DIVIDER;

    logic                               clk;
    logic                               rst;
    logic                               wr;
    logic                               rd;
    logic   [`PERIPH_ADDR_BITS-1:0]     addr;
    logic   [`PERIPH_DATA_BITS-1:0]     wdata;
    logic   [`PERIPH_DATA_BITS-1:0]     rdata;
    logic                               rvalid;
    logic                               err;
    logic   [`GPIO_BITS-1:0]            gpio;
    logic                               uart_tx;

    integer                             seed = 40340;
    int                                 checks = 0;
    int                                 value_errors = 0;
    int                                 timeout_errors = 0;
    logic   [`GPIO_BITS-1:0]            gpio_model;

    pmod_periph_top pmod_periph_top_inst (
        .clk     (clk     ),
        .rst     (rst     ),
        .wr      (wr      ),
        .rd      (rd      ),
        .addr    (addr    ),
        .wdata   (wdata   ),
        .rdata   (rdata   ),
        .rvalid  (rvalid  ),
        .err     (err     ),
        .gpio    (gpio    ),
        .uart_tx (uart_tx )
    );

    always #2 clk = ~clk;

    // --------------------
    //  checks
    // --------------------

    task automatic check_data(input string name, input logic [`PERIPH_DATA_BITS-1:0] got,
                              input logic [`PERIPH_DATA_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAILED time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_gpio(input string name, input logic [`GPIO_BITS-1:0] got,
                              input logic [`GPIO_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAILED time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAILED time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // expected pin value from the register map rules
    function automatic logic [`GPIO_BITS-1:0] gpio_next(input gpio_op_t op,
            input logic [`GPIO_BITS-1:0] cur, input logic [`GPIO_BITS-1:0] mask);
        case (op)
            op_write:  return mask;
            op_set:    return cur | mask;
            op_clear:  return cur & ~mask;
            default:   return cur ^ mask;
        endcase
    endfunction

    function automatic logic [`PERIPH_ADDR_BITS-1:0] gpio_addr(input gpio_op_t op);
        case (op)
            op_write:  return `ADDR_GPIO_WRITE;
            op_set:    return `ADDR_GPIO_SET;
            op_clear:  return `ADDR_GPIO_CLEAR;
            default:   return `ADDR_GPIO_TOGGLE;
        endcase
    endfunction

    // --------------------
    //  bus and line tasks
    // --------------------

    // all bus tasks start and end one unit after a rising edge
    task automatic bus_write(input logic [`PERIPH_ADDR_BITS-1:0] a,
                             input logic [`PERIPH_DATA_BITS-1:0] d, output logic err_seen);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(posedge clk);
        #1;
        wr       = 1'b0;
        err_seen = err;
    endtask

    task automatic bus_read(input logic [`PERIPH_ADDR_BITS-1:0] a,
                            output logic [`PERIPH_DATA_BITS-1:0] data, output logic err_seen);
        int waited;
        waited = 0;
        addr   = a;
        rd     = 1'b1;
        @(posedge clk);
        #1;
        rd = 1'b0;
        while (rvalid !== 1'b1 && waited < READ_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rvalid !== 1'b1) begin
            timeout_errors++;
            $display("timeout at %0t: no read response for address 0x%0h", $time, a);
        end else begin
            check_data("rvalid latency", waited, 0);
        end
        data     = rdata;
        err_seen = err;
        @(posedge clk);
        #1;
        check_bit("rvalid", rvalid, 1'b0);
    endtask

    // samples mid bit and returns at the middle of the stop bit
    task automatic uart_receive(output logic [7:0] data, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        data   = '0;
        @(negedge clk);
        while (uart_tx !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            timeout_errors++;
            $display("timeout at %0t: no start bit seen on uart_tx", $time);
            return;
        end
        repeat (`UART_DIVIDER / 2) @(negedge clk);
        check_bit("uart_tx start bit", uart_tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (`UART_DIVIDER) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (`UART_DIVIDER) @(negedge clk);
        check_bit("uart_tx stop bit", uart_tx, 1'b1);
        ok = 1'b1;
    endtask

    task automatic line_stays_idle(input int cycles);
        logic seen_low;
        seen_low = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (uart_tx !== 1'b1 && !seen_low) begin
                seen_low = 1'b1;
                check_bit("uart_tx idle", uart_tx, 1'b1);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic read_status(input logic exp_busy);
        logic [`PERIPH_DATA_BITS-1:0] d;
        logic e;
        bus_read(`ADDR_UART_STATUS, d, e);
        check_data("rdata status", d, `PERIPH_DATA_BITS'(exp_busy));
        check_bit("err", e, 1'b0);
    endtask

    // --------------------
    //  directed tests
    // --------------------

    task automatic test_reset_state();
        check_gpio("gpio", gpio, '0);
        check_bit("uart_tx", uart_tx, 1'b1);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("err", err, 1'b0);
        read_status(1'b0);
    endtask

    task automatic test_gpio_ops();
        logic [`GPIO_BITS-1:0] mask;
        logic [`PERIPH_DATA_BITS-1:0] d;
        logic e;
        gpio_op_t op;
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 4; k++) begin
                op         = gpio_op_t'(k);
                mask       = `GPIO_BITS'(random_word());
                gpio_model = gpio_next(op, gpio_model, mask);
                bus_write(gpio_addr(op), {28'h0, mask}, e);
                check_bit("err", e, 1'b0);
                check_gpio("gpio", gpio, gpio_model);
                bus_read(gpio_addr(op), d, e);
                check_data("rdata gpio", d, `PERIPH_DATA_BITS'(gpio_model));
                check_bit("err", e, 1'b0);
            end
        end
    endtask

    task automatic test_uart_frames();
        logic [7:0] sent;
        logic [7:0] got;
        logic [`PERIPH_DATA_BITS-1:0] st;
        logic ok;
        logic e;
        logic re;
        for (int i = 0; i < 4; i++) begin
            sent = 8'(random_word());
            bus_write(`ADDR_UART_DATA, {24'h0, sent}, e);
            check_bit("err", e, 1'b0);
            fork
                uart_receive(got, ok);
                begin
                    bus_read(`ADDR_UART_STATUS, st, re);
                    check_data("rdata status", st, 1);
                    check_bit("err", re, 1'b0);
                end
            join
            if (ok) begin
                check_byte("uart byte", got, sent);
            end
            // to the end of the stop bit
            repeat (`UART_DIVIDER / 2) @(posedge clk);
            #1;
            read_status(1'b0);
        end
    endtask

    task automatic test_write_while_busy();
        logic [7:0] first;
        logic [7:0] second;
        logic [7:0] got;
        logic ok;
        logic e;
        logic e2;
        first  = 8'(random_word());
        second = 8'(random_word());
        if (second == first) begin
            second = ~first;
        end
        bus_write(`ADDR_UART_DATA, {24'h0, first}, e);
        check_bit("err", e, 1'b0);
        fork
            uart_receive(got, ok);
            begin
                repeat (3 * `UART_DIVIDER) @(posedge clk);
                #1;
                bus_write(`ADDR_UART_DATA, {24'h0, second}, e2);
                check_bit("err", e2, 1'b0);
            end
        join
        if (ok) begin
            check_byte("uart byte", got, first);
        end
        line_stays_idle(2 * FRAME_CYCLES);
        read_status(1'b0);
    endtask

    task automatic test_bus_errors();
        logic [`PERIPH_ADDR_BITS-1:0] bad_rd [6] = '{4'h0, 4'h2, 4'h3, 4'h8, 4'hb, 4'hf};
        logic [`PERIPH_ADDR_BITS-1:0] bad_wr [6] = '{4'h1, 4'h2, 4'h3, 4'h9, 4'hc, 4'hf};
        logic [`PERIPH_DATA_BITS-1:0] d;
        logic e;
        gpio_model = `GPIO_BITS'(random_word());
        bus_write(`ADDR_GPIO_WRITE, {28'h0, gpio_model}, e);
        check_bit("err", e, 1'b0);
        check_gpio("gpio", gpio, gpio_model);
        foreach (bad_rd[i]) begin
            bus_read(bad_rd[i], d, e);
            check_data("rdata", d, '0);
            check_bit("err", e, 1'b1);
        end
        foreach (bad_wr[i]) begin
            bus_write(bad_wr[i], random_word(), e);
            check_bit("err", e, 1'b1);
            check_gpio("gpio", gpio, gpio_model);
            @(posedge clk);
            #1;
            check_bit("err", err, 1'b0);
        end
        line_stays_idle(2 * `UART_DIVIDER);
        check_gpio("gpio", gpio, gpio_model);
        read_status(1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        gpio_model = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_gpio_ops();
        test_uart_frames();
        test_write_while_busy();
        test_bus_errors();

        $display("checks=%0d value_errors=%0d timeouts=%0d",
                 checks, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* pmod_periph_top.f */
+incdir+.
periph_pkg.sv
periph_bus_decode.sv
periph_uart_tx.sv
periph_gpio_reg.sv
pmod_periph_top.sv
tb_pmod_periph_top.sv
